// File: picCtrl.f
+incdir+design
design/picPkg.sv
design/picBusRegs.sv
design/picRequestLatch.sv
design/picInServiceReg.sv
design/picVectorOut.sv
design/picCtrl.sv
tests/picClkGen.sv
tests/picCtrl_props.sv
tests/picCtrl_tb.sv

// File: tests/picCtrl_trace.txt
# op name a b, operands in hex
# write addr data | read addr expected | raise line | ack vector | intr value | wait cycles
write cfgWr 0 48
read cfgRd 0 48
write maskWr 4 f0
read maskRd 4 f0
ack spurious 4f
raise raiseIr2 2
raise raiseIr5 5
read statIrr c 24
intr intrOn 1
ack ackIr2 4a
wait settleIsr 2
read statIsr c 420
write unmask5 4 d0
wait settleMask 3
intr blocked 0
write eoiNs 8 08
wait settleEoi 2
intr unmasked 1
ack ackIr5 4d
raise raiseIr1 1
ack ackIr1 49
read statNest c 2200
write eoiSpec5 8 15
read statSpec c 200
write eoiNs2 8 08
read statClear c 0
write cfgAeoi 0 148
read cfgAeoiRd 0 148
raise prioIr3 3
raise prioIr0 0
raise prioIr2 2
ack prio0 48
ack prio2 4a
ack prio3 4b
read statAeoi c 0
write cfgNoAeoi 0 48
raise rotIr1 1
raise rotIr3 3
ack rotAck1 49
write eoiRot 8 18
raise rotIr0 0
ack rotAck3 4b
ack rotBlocked 4f
write eoiNs3 8 08
ack rotAck0 48
read statRot c 100

// File: tests/picCtrl_tb.sv
`default_nettype none

`include "picCtrl_consts.svh"

module picCtrl_tb;

  logic                     clk;
  logic                     arstN;
  logic [`PIC_ADDR_W-1:0]   awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [`PIC_DATA_W-1:0]   wdata;
  logic [`PIC_DATA_W/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [`PIC_ADDR_W-1:0]   araddr;
  logic                     arvalid;
  logic                     arready;
  logic [`PIC_DATA_W-1:0]   rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;
  logic [`PIC_LINES-1:0]    ir;
  logic                     inta;
  logic                     intr;
  logic [7:0]               vector;
  logic                     vectorValid;

  logic [8*16-1:0] opArr   [0:255];  // Trace opcode per line
  logic [8*16-1:0] nameArr [0:255];  // Test name per line
  logic [31:0]     aArr    [0:255];
  logic [31:0]     bArr    [0:255];
  int              nOps;
  logic            traceLoaded;
  int              errCount;
  int              seedVal;

  picClkGen u_clkGen (.clk(clk));

  picCtrl u_dut (.*);

  bind picCtrl picCtrl_props u_props (
    .clk, .arstN, .awready, .bvalid, .bready, .rvalid, .rready, .inta, .vectorValid
  );

  task automatic reportMismatch(input logic [8*16-1:0] name, input logic [31:0] exp,
                                input logic [31:0] act);
    $display("mismatch %0s expected 0x%0h actual 0x%0h", name, exp, act);
    errCount++;
    $display("Test failures found");
    $fatal(1, "check failed");
  endtask

  task automatic reportError(input logic [8*16-1:0] name, input string msg);
    $display("error in %0s: %0s", name, msg);
    errCount++;
    $display("Test failures found");
    $fatal(1, "check failed");
  endtask

  task automatic randomGap();
    int gap;
    gap = $urandom % 4;  // Zero to three idle cycles
    repeat (gap) @(posedge clk);
  endtask

  task automatic loadTrace();
    int              fd;
    string           line;
    logic [8*16-1:0] op;
    logic [8*16-1:0] name;
    logic [31:0]     a;
    logic [31:0]     b;
    fd = $fopen("tests/picCtrl_trace.txt", "r");
    assert (fd != 0) else reportError("loadTrace", "cannot open the trace file");
    nOps = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") begin  // Skip column notes and blanks
        a = '0;
        b = '0;
        void'($sscanf(line, "%s %s %h %h", op, name, a, b));
        opArr[nOps]   = op;
        nameArr[nOps] = name;
        aArr[nOps]    = a;
        bArr[nOps]    = b;
        nOps++;
      end
    end
    $fclose(fd);
  endtask

  task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data,
                          input logic [8*16-1:0] name);
    @(posedge clk);
    awaddr  <= addr[`PIC_ADDR_W-1:0];
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= '1;
    wvalid  <= 1'b1;
    do @(negedge clk); while (!(awready && wready));  // Taken on the next edge
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    randomGap();  // Late bready
    @(posedge clk);
    bready <= 1'b1;
    do @(negedge clk); while (!bvalid);
    assert (bresp == 2'b00) else reportMismatch(name, 0, bresp);
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axiRead(input logic [31:0] addr, input logic [8*16-1:0] name,
                         output logic [31:0] data);
    @(posedge clk);
    araddr  <= addr[`PIC_ADDR_W-1:0];
    arvalid <= 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    randomGap();  // Late rready
    @(posedge clk);
    rready <= 1'b1;
    do @(negedge clk); while (!rvalid);
    data = rdata;
    assert (rresp == 2'b00) else reportMismatch(name, 0, rresp);
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // Edge on one line, then poll STAT until its IRR bit shows up
  task automatic raiseLine(input logic [31:0] line, input logic [8*16-1:0] name);
    logic [31:0] stat;
    logic        seen;
    seen = 1'b0;
    @(posedge clk);
    ir[line[`PIC_IDX_W-1:0]] <= 1'b1;
    for (int t = 0; t < 8 && !seen; t++) begin
      axiRead(`PIC_ADDR_STAT, name, stat);
      seen = stat[line[`PIC_IDX_W-1:0]];
    end
    @(posedge clk);
    ir[line[`PIC_IDX_W-1:0]] <= 1'b0;
    assert (seen) else reportError(name, "request bit never appeared in STAT");
  endtask

  task automatic ackCheck(input logic [31:0] expVec, input logic [8*16-1:0] name);
    @(posedge clk);
    inta <= 1'b1;
    @(posedge clk);
    inta <= 1'b0;
    @(negedge clk);  // Vector cycle right after the pulse
    assert (vectorValid) else reportError(name, "vectorValid missing after inta");
    assert (vector == expVec[7:0]) else reportMismatch(name, expVec, vector);
  endtask

  task automatic runOp(input int idx);
    logic [31:0] data;
    randomGap();
    if (opArr[idx] == "write") begin
      axiWrite(aArr[idx], bArr[idx], nameArr[idx]);
    end else if (opArr[idx] == "read") begin
      axiRead(aArr[idx], nameArr[idx], data);
      assert (data == bArr[idx]) else reportMismatch(nameArr[idx], bArr[idx], data);
    end else if (opArr[idx] == "raise") begin
      raiseLine(aArr[idx], nameArr[idx]);
    end else if (opArr[idx] == "ack") begin
      ackCheck(aArr[idx], nameArr[idx]);
    end else if (opArr[idx] == "intr") begin
      @(negedge clk);
      assert (intr == aArr[idx][0]) else reportMismatch(nameArr[idx], aArr[idx], intr);
    end else if (opArr[idx] == "wait") begin
      repeat (aArr[idx]) @(posedge clk);
    end else begin
      reportError(nameArr[idx], "unknown trace opcode");
    end
  endtask

  // Watchdog sized from the trace length
  initial begin
    wait (traceLoaded);
    repeat (nOps * 64) @(posedge clk);
    $display("timeout, trace not finished after %0d cycles", nOps * 64);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    arstN       = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    ir          = '0;
    inta        = 1'b0;
    errCount    = 0;
    traceLoaded = 1'b0;
    seedVal     = $urandom(31);  // Seed once for the whole run
    loadTrace();
    traceLoaded = 1'b1;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    for (int i = 0; i < nOps; i++) begin
      runOp(i);
    end
    repeat (2) @(posedge clk);
    if (errCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/picCtrl_props.sv
`default_nettype none

module picCtrl_props (
  input wire clk,
  input wire arstN,
  input wire awready,
  input wire bvalid,
  input wire bready,
  input wire rvalid,
  input wire rready,
  input wire inta,
  input wire vectorValid
);

  // Write response held until the master takes it
  bHoldA: assert property (@(posedge clk) disable iff (!arstN)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // Read data held until the master takes it
  rHoldA: assert property (@(posedge clk) disable iff (!arstN)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  bBlockA: assert property (@(posedge clk) disable iff (!arstN)
    bvalid |-> !awready)  // No new write while a response is owed
    else $error("awready high with bvalid pending");

  vecAfterAckA: assert property (@(posedge clk) disable iff (!arstN)
    inta |=> vectorValid)  // Every acknowledge yields a vector
    else $error("no vectorValid after inta");

  vecOnlyAfterAckA: assert property (@(posedge clk) disable iff (!arstN)
    vectorValid |-> $past(inta))  // One cycle per inta, never longer
    else $error("vectorValid without inta in the previous cycle");

endmodule

`default_nettype wire

// File: tests/picClkGen.sv
`default_nettype none

module picClkGen (
  output logic clk  // Free-running testbench clock
);

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;  // Period 8

endmodule

`default_nettype wire

// File: design/picCtrl.sv
`default_nettype none

`include "picCtrl_consts.svh"

module picCtrl
  import picPkg::*;
(
  input  wire                      clk,
  input  wire                      arstN,
  // AXI4-Lite configuration slave
  input  wire  [`PIC_ADDR_W-1:0]   awaddr,
  input  wire                      awvalid,
  output logic                     awready,
  input  wire  [`PIC_DATA_W-1:0]   wdata,
  input  wire  [`PIC_DATA_W/8-1:0] wstrb,
  input  wire                      wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  wire                      bready,
  input  wire  [`PIC_ADDR_W-1:0]   araddr,
  input  wire                      arvalid,
  output logic                     arready,
  output logic [`PIC_DATA_W-1:0]   rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  wire                      rready,
  // Interrupt side
  input  wire  [`PIC_LINES-1:0]    ir,
  input  wire                      inta,
  output logic                     intr,
  output logic [7:0]               vector,
  output logic                     vectorValid
);

  wire picCfg_t               cfg;       // To ISR and vector blocks
  wire [`PIC_LINES-1:0]       mask;
  wire eoiCmd_t               eoiCmd;
  wire [`PIC_LINES-1:0]       irr;
  wire [`PIC_LINES-1:0]       pending;
  wire [`PIC_LINES-1:0]       isr;
  wire [`PIC_LINES-1:0]       clearReq;
  wire grant_t                grant;

  picBusRegs u_busRegs (
    .clk, .arstN,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .irr, .isr, .cfg, .mask, .eoiCmd
  );

  picRequestLatch u_reqLatch (
    .clk, .arstN, .ir, .mask, .clearReq, .irr, .pending
  );

  picInServiceReg u_inService (
    .clk, .arstN, .pending, .cfg, .eoiCmd, .inta,
    .isr, .intr, .grant, .clearReq
  );

  picVectorOut u_vectorOut (
    .clk, .arstN, .grant, .inta, .cfg, .vector, .vectorValid
  );

endmodule

`default_nettype wire

// File: design/picVectorOut.sv
`default_nettype none

`include "picCtrl_consts.svh"

module picVectorOut
  import picPkg::*;
(
  input  wire          clk,
  input  wire          arstN,
  input  wire  grant_t grant,      // Level granted by the ISR block
  input  wire          inta,       // Acknowledge pulse
  input  wire  picCfg_t cfg,
  output logic [7:0]   vector,     // Base followed by level
  output logic         vectorValid
);

  ackState_t             state;
  logic [`PIC_IDX_W-1:0] levelQ;   // Captured level for the vector byte

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= ackIdle;
    end else begin
      case (state)
        ackIdle: begin
          if (inta) begin
            state <= ackPresent;
          end
        end
        ackPresent: begin
          if (!inta) begin
            state <= ackIdle;      // Back-to-back inta stays here
          end
        end
        default: state <= ackIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (inta) begin
      // No grant means spurious, reported as IR7
      levelQ <= grant.valid ? grant.level : {`PIC_IDX_W{1'b1}};
    end
  end

  assign vector      = {cfg.vectorBase, levelQ};
  assign vectorValid = (state == ackPresent);

endmodule

`default_nettype wire

// File: design/picInServiceReg.sv
`default_nettype none

`include "picCtrl_consts.svh"

module picInServiceReg
  import picPkg::*;
(
  input  wire                   clk,
  input  wire                   arstN,
  input  wire  [`PIC_LINES-1:0] pending,   // Unmasked requests from the latch
  input  wire  picCfg_t         cfg,
  input  wire  eoiCmd_t         eoiCmd,
  input  wire                   inta,      // Single-cycle acknowledge
  output logic [`PIC_LINES-1:0] isr,       // In-service register
  output logic                  intr,      // Registered interrupt request
  output grant_t                grant,     // Level taken by this inta
  output logic [`PIC_LINES-1:0] clearReq   // One-hot IRR clear
);

  logic [`PIC_IDX_W-1:0] lowest;           // Lowest-priority level
  logic [`PIC_IDX_W-1:0] lowestNext;
  logic [`PIC_IDX_W-1:0] topLevel;         // Highest-priority level, one above lowest
  grant_t                pendTop;          // Best pending level
  grant_t                servTop;          // Best in-service level
  logic [`PIC_IDX_W-1:0] pendRank;         // Distance from topLevel, 0 is best
  logic [`PIC_IDX_W-1:0] servRank;
  logic                  pendWins;         // Pending outranks everything in service
  logic [`PIC_LINES-1:0] setMask;          // ISR bits set on acknowledge
  logic [`PIC_LINES-1:0] clrMask;          // ISR bits cleared by EOI

  // Circular scan, first set bit from start upwards with wrap
  function automatic grant_t scanFrom(input logic [`PIC_LINES-1:0] vec,
                                      input logic [`PIC_IDX_W-1:0] start);
    grant_t                hit;
    logic [`PIC_IDX_W-1:0] idx;
    hit = '0;
    for (int i = 0; i < `PIC_LINES; i++) begin
      idx = start + `PIC_IDX_W'(i);        // Index wraps modulo eight
      if (vec[idx] && !hit.valid) begin
        hit.valid = 1'b1;
        hit.level = idx;
      end
    end
    return hit;
  endfunction

  assign topLevel = lowest + 1'b1;
  assign pendTop  = scanFrom(pending, topLevel);
  assign servTop  = scanFrom(isr, topLevel);
  assign pendRank = pendTop.level - topLevel;
  assign servRank = servTop.level - topLevel;
  // Equal rank blocks, a level cannot nest on itself
  assign pendWins = pendTop.valid && (!servTop.valid || (pendRank < servRank));

  // Acknowledge takes the winning level in the same cycle
  always_comb begin
    grant.valid = inta && pendWins;
    grant.level = pendTop.level;
    clearReq    = '0;
    setMask     = '0;
    if (grant.valid) begin
      clearReq[pendTop.level] = 1'b1;
      if (!cfg.autoEoi) begin
        setMask[pendTop.level] = 1'b1;     // AEOI leaves ISR untouched
      end
    end
  end

  // End-of-interrupt decode
  always_comb begin
    clrMask    = '0;
    lowestNext = lowest;
    if (eoiCmd.valid) begin
      case (eoiCmd.op)
        eoiNonSpecific: begin
          if (servTop.valid) begin
            clrMask[servTop.level] = 1'b1;
          end
        end
        eoiSpecific: clrMask[eoiCmd.level] = 1'b1;
        eoiRotateNonSpecific: begin
          if (servTop.valid) begin
            clrMask[servTop.level] = 1'b1;
            lowestNext = servTop.level;    // Serviced level drops to the bottom
          end
        end
        eoiSetLowest: lowestNext = eoiCmd.level;
        default: begin
          // eoiNone, nothing changes
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      isr    <= '0;
      lowest <= `PIC_IDX_W'(`PIC_LINES - 1); // IR7 lowest, IR0 highest
      intr   <= 1'b0;
    end else begin
      isr    <= (isr & ~clrMask) | setMask;  // Acknowledge set wins over EOI clear
      lowest <= lowestNext;
      intr   <= pendWins;
    end
  end

endmodule

`default_nettype wire

// File: design/picRequestLatch.sv
`default_nettype none

`include "picCtrl_consts.svh"

module picRequestLatch (
  input  wire                   clk,
  input  wire                   arstN,
  input  wire  [`PIC_LINES-1:0] ir,        // Asynchronous interrupt lines
  input  wire  [`PIC_LINES-1:0] mask,      // 1 blocks the line
  input  wire  [`PIC_LINES-1:0] clearReq,  // One-hot clear from the acknowledge
  output logic [`PIC_LINES-1:0] irr,       // Interrupt request register
  output logic [`PIC_LINES-1:0] pending    // Unmasked requests
);

  logic [`PIC_LINES-1:0] syncQ1;           // First synchronizer stage
  logic [`PIC_LINES-1:0] syncQ2;           // Second synchronizer stage
  logic [`PIC_LINES-1:0] irDly;            // Previous synchronized level
  logic [`PIC_LINES-1:0] riseEdge;         // Low to high seen this cycle

  assign riseEdge = syncQ2 & ~irDly;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      syncQ1 <= '0;
      syncQ2 <= '0;
      irDly  <= '0;
      irr    <= '0;
    end else begin
      syncQ1 <= ir;
      syncQ2 <= syncQ1;
      irDly  <= syncQ2;
      // A new edge outranks a clear in the same cycle
      irr    <= (irr & ~clearReq) | riseEdge;
    end
  end

  assign pending = irr & ~mask;            // Masked lines stay visible in IRR only

endmodule

`default_nettype wire

// File: design/picBusRegs.sv
`default_nettype none

`include "picCtrl_consts.svh"

module picBusRegs
  import picPkg::*;
(
  input  wire                         clk,
  input  wire                         arstN,
  // AXI4-Lite write address/data/response
  input  wire  [`PIC_ADDR_W-1:0]      awaddr,
  input  wire                         awvalid,
  output logic                        awready,
  input  wire  [`PIC_DATA_W-1:0]      wdata,
  input  wire  [`PIC_DATA_W/8-1:0]    wstrb,
  input  wire                         wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  wire                         bready,
  // AXI4-Lite read address/data
  input  wire  [`PIC_ADDR_W-1:0]      araddr,
  input  wire                         arvalid,
  output logic                        arready,
  output logic [`PIC_DATA_W-1:0]      rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  wire                         rready,
  // Status sources
  input  wire  [`PIC_LINES-1:0]       irr,
  input  wire  [`PIC_LINES-1:0]       isr,
  // Configuration and commands out
  output picCfg_t                     cfg,
  output logic [`PIC_LINES-1:0]       mask,
  output eoiCmd_t                     eoiCmd
);

  logic                   wrAccept;   // Write taken this cycle
  logic                   rdAccept;   // Read taken this cycle
  logic [`PIC_DATA_W-1:0] rdMux;      // Read data selected by araddr

  // Opcode field to enum, unknown codes do nothing
  function automatic eoiOp_t decodeOp(input logic [2:0] raw);
    eoiOp_t op;
    case (raw)
      3'd1:    op = eoiNonSpecific;
      3'd2:    op = eoiSpecific;
      3'd3:    op = eoiRotateNonSpecific;
      3'd4:    op = eoiSetLowest;
      default: op = eoiNone;
    endcase
    return op;
  endfunction

  assign awready  = !bvalid;                      // Both ready while no response owed
  assign wready   = !bvalid;
  assign wrAccept = awvalid && wvalid && !bvalid; // Address and data together
  assign bresp    = 2'b00;                        // Always OKAY

  assign arready  = !rvalid;                      // One read outstanding at most
  assign rdAccept = arvalid && !rvalid;
  assign rresp    = 2'b00;                        // OKAY, undefined addresses read zero

  // Write side, registers update with bvalid rising
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      bvalid <= 1'b0;
      cfg    <= '0;
      mask   <= `PIC_MASK_RST;
      eoiCmd <= '0;
    end else begin
      eoiCmd.valid <= 1'b0;                       // Command is a single-cycle pulse
      if (bvalid && bready) begin
        bvalid <= 1'b0;                           // Response taken
      end
      if (wrAccept) begin
        bvalid <= 1'b1;
        case (awaddr)
          `PIC_ADDR_CFG: begin
            if (wstrb[0]) begin
              cfg.vectorBase <= wdata[7:3];       // Byte 0 holds the base
            end
            if (wstrb[1]) begin
              cfg.autoEoi <= wdata[8];            // Byte 1 holds AEOI
            end
          end
          `PIC_ADDR_MASK: begin
            if (wstrb[0]) begin
              mask <= wdata[`PIC_LINES-1:0];
            end
          end
          `PIC_ADDR_CMD: begin
            if (wstrb[0]) begin
              eoiCmd.valid <= 1'b1;
              eoiCmd.op    <= decodeOp(wdata[5:3]);
              eoiCmd.level <= wdata[`PIC_IDX_W-1:0];
            end
          end
          default: begin
            // STAT and unmapped writes are dropped, still answered OKAY
          end
        endcase
      end
    end
  end

  // Read data selection
  always_comb begin
    rdMux = '0;
    case (araddr)
      `PIC_ADDR_CFG: begin
        rdMux[7:3] = cfg.vectorBase;
        rdMux[8]   = cfg.autoEoi;
      end
      `PIC_ADDR_MASK: rdMux[`PIC_LINES-1:0] = mask;
      `PIC_ADDR_STAT: begin
        rdMux[`PIC_LINES-1:0]            = irr;   // Low byte IRR
        rdMux[2*`PIC_LINES-1:`PIC_LINES] = isr;   // Next byte ISR
      end
      default: rdMux = '0;                        // CMD is write only
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rvalid <= 1'b0;
    end else if (rdAccept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;                             // Held until the master takes it
    end
  end

  always_ff @(posedge clk) begin
    if (rdAccept) begin
      rdata <= rdMux;                             // Sampled at acceptance
    end
  end

endmodule

`default_nettype wire

// File: design/picPkg.sv
`default_nettype none

`include "picCtrl_consts.svh"

package picPkg;

  // OCW2-style end-of-interrupt opcodes, CMD bits 5:3
  typedef enum logic [2:0] {
    eoiNone              = 3'd0,  // No operation
    eoiNonSpecific       = 3'd1,  // Clear highest-priority ISR bit
    eoiSpecific          = 3'd2,  // Clear the named ISR bit
    eoiRotateNonSpecific = 3'd3,  // Non-specific, cleared level becomes lowest
    eoiSetLowest         = 3'd4   // Set lowest-priority level only
  } eoiOp_t;

  // Acknowledge sequencer states
  typedef enum logic {
    ackIdle,                      // Waiting for inta
    ackPresent                    // Vector byte on the output
  } ackState_t;

  // Configuration from the CFG register
  typedef struct packed {
    logic [4:0] vectorBase;       // Upper five bits of the vector byte
    logic       autoEoi;          // ISR not set on acknowledge
  } picCfg_t;

  // One-cycle EOI command from a CMD write
  typedef struct packed {
    logic                  valid; // Pulse per accepted CMD write
    eoiOp_t                op;    // Decoded opcode
    logic [`PIC_IDX_W-1:0] level; // Target level for specific forms
  } eoiCmd_t;

  // Granted level, also used as scan result
  typedef struct packed {
    logic                  valid;
    logic [`PIC_IDX_W-1:0] level;
  } grant_t;

endpackage

`default_nettype wire

// File: design/picCtrl_consts.svh
`ifndef PIC_CTRL_CONSTS_SVH
`define PIC_CTRL_CONSTS_SVH

// Interrupt line geometry, fixed by the 8259A model
`define PIC_LINES      8          // IR0..IR7
`define PIC_IDX_W      3          // Level index width

// AXI4-Lite configuration port
`define PIC_ADDR_W     4          // Byte address width
`define PIC_DATA_W     32         // Data bus width

// Register map, byte addresses
`define PIC_ADDR_CFG   4'h0       // Vector base and auto-EOI enable
`define PIC_ADDR_MASK  4'h4       // Interrupt mask, one bit per line
`define PIC_ADDR_CMD   4'h8       // End-of-interrupt commands, write only
`define PIC_ADDR_STAT  4'hC       // IRR and ISR snapshot, read only

// Reset values
`define PIC_MASK_RST   8'hFF      // All lines masked out of reset

`endif
